// ==== gb_bus_cfg.svh ====
`ifndef GB_BUS_CFG_SVH
`define GB_BUS_CFG_SVH

// Bus widths.
`define GB_ADR_W        16
`define GB_DATA_W       8
`define GB_IDX_W        13

// Region limits of the 16-bit map, IO fills the gaps.
`define GB_ROM_LIMIT    16'h7FFF
`define GB_VRAM_BASE    16'h8000
`define GB_VRAM_LIMIT   16'h9FFF
`define GB_XRAM_LIMIT   16'hBFFF
`define GB_WRAM_LIMIT   16'hFDFF
`define GB_OAM_BASE     16'hFE00
`define GB_OAM_LIMIT    16'hFE9F
`define GB_HRAM_BASE    16'hFF80
`define GB_HRAM_LIMIT   16'hFFFE

`define GB_VRAM_DEPTH   8192
`define GB_OAM_DEPTH    160
`define GB_HRAM_DEPTH   127
`define GB_OPEN_BUS     8'hFF

`endif

// ==== gb_map_pkg.sv ====
`default_nettype none

`include "gb_bus_cfg.svh"

package gb_map_pkg;

	// Full bus address as seen by every master.
	typedef logic [`GB_ADR_W-1:0] gb_adr_t;

	typedef logic [`GB_DATA_W-1:0] gb_data_t;

	// Word index into one of the local memories.
	typedef logic [`GB_IDX_W-1:0] gb_idx_t;

	// Target selected by an address.
	typedef enum logic [2:0] {
		RGN_ROM,
		RGN_VRAM,
		RGN_XRAM,
		RGN_WRAM,
		RGN_OAM,
		RGN_HRAM,
		RGN_NONE
	} gb_region_e;

endpackage

`default_nettype wire

// ==== gb_bus_pkg.sv ====
`default_nettype none

package gb_bus_pkg;

	import gb_map_pkg::*;

	typedef struct packed {
		logic     rd;
		logic     wr;
		gb_adr_t  adr;
		gb_data_t wdata;
	} cpu_req_t;

	// Source read by adr, OAM written by oam_idx.
	typedef struct packed {
		logic     active;
		logic     rd;
		gb_adr_t  adr;
		logic     wr;
		gb_idx_t  oam_idx;
		gb_data_t wdata;
	} dma_req_t;

	typedef struct packed {
		logic    need_vram;
		logic    need_oam;
		logic    rd;
		gb_adr_t adr;
	} ppu_req_t;

	typedef struct packed {
		logic     valid;
		gb_data_t data;
	} rsp_t;

	typedef struct packed {
		gb_adr_t  adr;
		logic     rd;
		logic     wr;
		gb_data_t wdata;
		logic     oe;
		logic     cs_rom;
		logic     cs_xram;
		logic     cs_wram;
	} ext_bus_t;

	typedef struct packed {
		logic     rd;
		logic     wr;
		gb_idx_t  idx;
		gb_data_t wdata;
	} mem_port_t;

	// Where a pending read gets its byte.
	typedef enum logic [2:0] {
		SRC_OPEN,
		SRC_VRAM,
		SRC_OAM,
		SRC_HRAM,
		SRC_EXT
	} gb_src_e;

	typedef struct packed {
		logic    valid;
		gb_src_e src;
	} rsp_tag_t;

endpackage

`default_nettype wire

// ==== gb_region_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_bus_cfg.svh"

module gb_region_decode
	import gb_map_pkg::*, gb_bus_pkg::*;
#(
	parameter type req_t = cpu_req_t
) (
	input  req_t       req,
	input  logic       enable,
	output gb_region_e region
);

	gb_adr_t adr;

	assign adr = req.adr;

	// Regions are contiguous up to OAM, so upper limits are enough there.
	always_comb begin
		if (!enable) begin
			region = RGN_NONE;
		end else if (adr <= `GB_ROM_LIMIT) begin
			region = RGN_ROM;
		end else if (adr >= `GB_VRAM_BASE && adr <= `GB_VRAM_LIMIT) begin
			region = RGN_VRAM;
		end else if (adr <= `GB_XRAM_LIMIT) begin
			region = RGN_XRAM;
		end else if (adr <= `GB_WRAM_LIMIT) begin
			region = RGN_WRAM;
		end else if (adr >= `GB_OAM_BASE && adr <= `GB_OAM_LIMIT) begin
			region = RGN_OAM;
		end else if (adr >= `GB_HRAM_BASE && adr <= `GB_HRAM_LIMIT) begin
			region = RGN_HRAM;
		end else begin
			// IO space and the interrupt enable byte.
			region = RGN_NONE;
		end
	end

endmodule

`default_nettype wire

// ==== gb_bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_bus_cfg.svh"

module gb_bus_arbiter
	import gb_map_pkg::*, gb_bus_pkg::*;
(
	input  logic       gbclk,
	input  logic       arst_n,
	input  cpu_req_t   cpu_req,
	input  dma_req_t   dma_req,
	input  ppu_req_t   ppu_req,
	input  gb_region_e cpu_region,
	input  gb_region_e dma_region,
	output mem_port_t  vram_port,
	output mem_port_t  oam_port,
	output mem_port_t  hram_port,
	output ext_bus_t   ext_acc,
	output rsp_tag_t   cpu_tag,
	output rsp_tag_t   dma_tag,
	output rsp_tag_t   ppu_tag
);

	logic       ppu_vram, dma_vram, cpu_vram;
	logic       ppu_oam, dma_oam, cpu_oam;
	logic       cpu_hram;
	logic       dma_ext, cpu_ext;
	gb_region_e ext_region;
	rsp_tag_t   cpu_tag_d, dma_tag_d, ppu_tag_d;

	function automatic gb_idx_t to_idx(input gb_adr_t adr, input gb_adr_t base);
		return gb_idx_t'(adr - base);
	endfunction

	function automatic logic is_ext(input gb_region_e region);
		return region inside {RGN_ROM, RGN_XRAM, RGN_WRAM};
	endfunction

	// Pixel unit first, DMA second, CPU last.
	assign ppu_vram = ppu_req.need_vram;
	assign dma_vram = !ppu_vram && dma_region == RGN_VRAM;
	assign cpu_vram = !ppu_vram && !dma_vram && cpu_region == RGN_VRAM;
	assign ppu_oam  = ppu_req.need_oam;
	assign dma_oam  = !ppu_oam && dma_req.active;
	assign cpu_oam  = !ppu_oam && !dma_req.active && cpu_region == RGN_OAM;
	assign cpu_hram = cpu_region == RGN_HRAM;
	assign dma_ext  = is_ext(dma_region);
	assign cpu_ext  = !dma_ext && is_ext(cpu_region);

	always_comb begin
		vram_port = '0;
		if (ppu_vram) begin
			vram_port.rd  = ppu_req.rd;
			vram_port.idx = to_idx(ppu_req.adr, `GB_VRAM_BASE);
		end else if (dma_vram) begin
			vram_port.rd  = dma_req.rd;
			vram_port.idx = to_idx(dma_req.adr, `GB_VRAM_BASE);
		end else if (cpu_vram) begin
			vram_port.rd    = cpu_req.rd;
			vram_port.wr    = cpu_req.wr;
			vram_port.idx   = to_idx(cpu_req.adr, `GB_VRAM_BASE);
			vram_port.wdata = cpu_req.wdata;
		end
	end

	always_comb begin
		oam_port = '0;
		if (ppu_oam) begin
			// A pixel read goes to VRAM when both flags are up.
			oam_port.rd  = ppu_req.rd && !ppu_vram;
			oam_port.idx = to_idx(ppu_req.adr, `GB_OAM_BASE);
		end else if (dma_oam) begin
			oam_port.wr    = dma_req.wr;
			oam_port.idx   = dma_req.oam_idx;
			oam_port.wdata = dma_req.wdata;
		end else if (cpu_oam) begin
			oam_port.rd    = cpu_req.rd;
			oam_port.wr    = cpu_req.wr;
			oam_port.idx   = to_idx(cpu_req.adr, `GB_OAM_BASE);
			oam_port.wdata = cpu_req.wdata;
		end
	end

	always_comb begin
		hram_port       = '0;
		hram_port.idx   = to_idx(cpu_req.adr, `GB_HRAM_BASE);
		hram_port.wdata = cpu_req.wdata;
		if (cpu_hram) begin
			hram_port.rd = cpu_req.rd;
			hram_port.wr = cpu_req.wr;
		end
	end

	// The DMA holds the external bus for its whole source region.
	always_comb begin
		ext_acc       = '0;
		ext_acc.adr   = cpu_req.adr;
		ext_acc.wdata = cpu_req.wdata;
		ext_region    = RGN_NONE;
		if (dma_ext) begin
			ext_acc.adr = dma_req.adr;
			ext_acc.rd  = dma_req.rd;
			ext_region  = dma_region;
		end else if (cpu_ext) begin
			ext_acc.rd = cpu_req.rd;
			ext_acc.wr = cpu_req.wr;
			ext_region = cpu_region;
		end
		ext_acc.oe      = ext_acc.wr;
		ext_acc.cs_rom  = (ext_acc.rd || ext_acc.wr) && ext_region == RGN_ROM;
		ext_acc.cs_xram = (ext_acc.rd || ext_acc.wr) && ext_region == RGN_XRAM;
		ext_acc.cs_wram = (ext_acc.rd || ext_acc.wr) && ext_region == RGN_WRAM;
	end

	always_comb begin
		cpu_tag_d.valid = cpu_req.rd;
		if (cpu_vram)
			cpu_tag_d.src = SRC_VRAM;
		else if (cpu_oam)
			cpu_tag_d.src = SRC_OAM;
		else if (cpu_hram)
			cpu_tag_d.src = SRC_HRAM;
		else if (cpu_ext)
			cpu_tag_d.src = SRC_EXT;
		else
			cpu_tag_d.src = SRC_OPEN;

		dma_tag_d.valid = dma_req.rd;
		dma_tag_d.src   = dma_vram ? SRC_VRAM : (dma_ext ? SRC_EXT : SRC_OPEN);

		ppu_tag_d.valid = ppu_req.rd;
		ppu_tag_d.src   = ppu_vram ? SRC_VRAM : (ppu_oam ? SRC_OAM : SRC_OPEN);
	end

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			cpu_tag <= '0;
			dma_tag <= '0;
			ppu_tag <= '0;
		end else begin
			cpu_tag <= cpu_tag_d;
			dma_tag <= dma_tag_d;
			ppu_tag <= ppu_tag_d;
		end
	end

endmodule

`default_nettype wire

// ==== gb_local_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_bus_cfg.svh"

module gb_local_mem
	import gb_map_pkg::*, gb_bus_pkg::*;
(
	input  logic      gbclk,
	input  mem_port_t vram_port,
	input  mem_port_t oam_port,
	input  mem_port_t hram_port,
	output gb_data_t  vram_rdata,
	output gb_data_t  oam_rdata,
	output gb_data_t  hram_rdata
);

	localparam int OAM_AW  = $clog2(`GB_OAM_DEPTH);
	localparam int HRAM_AW = $clog2(`GB_HRAM_DEPTH);

	gb_data_t vram_mem [`GB_VRAM_DEPTH];
	gb_data_t oam_mem  [`GB_OAM_DEPTH];
	gb_data_t hram_mem [`GB_HRAM_DEPTH];

	// VRAM index spans the whole array.
	always_ff @(posedge gbclk) begin
		if (vram_port.wr)
			vram_mem[vram_port.idx] <= vram_port.wdata;
		if (vram_port.rd)
			vram_rdata <= vram_mem[vram_port.idx];
	end

	always_ff @(posedge gbclk) begin
		if (oam_port.wr)
			oam_mem[oam_port.idx[OAM_AW-1:0]] <= oam_port.wdata;
		if (oam_port.rd)
			oam_rdata <= oam_mem[oam_port.idx[OAM_AW-1:0]];
	end

	always_ff @(posedge gbclk) begin
		if (hram_port.wr)
			hram_mem[hram_port.idx[HRAM_AW-1:0]] <= hram_port.wdata;
		if (hram_port.rd)
			hram_rdata <= hram_mem[hram_port.idx[HRAM_AW-1:0]];
	end

endmodule

`default_nettype wire

// ==== gb_read_return.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gb_bus_cfg.svh"

module gb_read_return
	import gb_map_pkg::*, gb_bus_pkg::*;
(
	input  logic     gbclk,
	input  logic     arst_n,
	input  ext_bus_t ext_acc,
	input  gb_data_t ext_rdata,
	input  rsp_tag_t cpu_tag,
	input  rsp_tag_t dma_tag,
	input  rsp_tag_t ppu_tag,
	input  gb_data_t vram_rdata,
	input  gb_data_t oam_rdata,
	input  gb_data_t hram_rdata,
	output ext_bus_t ext,
	output rsp_t     cpu_rsp,
	output rsp_t     dma_rsp,
	output rsp_t     ppu_rsp
);

	gb_adr_t  adr_q;
	gb_data_t wdata_q;
	logic     rd_q, wr_q, oe_q;
	logic     cs_rom_q, cs_xram_q, cs_wram_q;
	logic     cpu_valid_q, dma_valid_q, ppu_valid_q;
	gb_data_t cpu_data_q, dma_data_q, ppu_data_q;

	function automatic gb_data_t pick(input gb_src_e src);
		case (src)
			SRC_VRAM: return vram_rdata;
			SRC_OAM:  return oam_rdata;
			SRC_HRAM: return hram_rdata;
			SRC_EXT:  return ext_rdata;
			default:  return `GB_OPEN_BUS;
		endcase
	endfunction

	always_ff @(posedge gbclk or negedge arst_n) begin
		if (!arst_n) begin
			rd_q        <= 1'b0;
			wr_q        <= 1'b0;
			oe_q        <= 1'b0;
			cs_rom_q    <= 1'b0;
			cs_xram_q   <= 1'b0;
			cs_wram_q   <= 1'b0;
			cpu_valid_q <= 1'b0;
			dma_valid_q <= 1'b0;
			ppu_valid_q <= 1'b0;
		end else begin
			rd_q        <= ext_acc.rd;
			wr_q        <= ext_acc.wr;
			// Data keeps driving one cycle after the write strobe.
			oe_q        <= ext_acc.oe || wr_q;
			cs_rom_q    <= ext_acc.cs_rom;
			cs_xram_q   <= ext_acc.cs_xram;
			cs_wram_q   <= ext_acc.cs_wram;
			cpu_valid_q <= cpu_tag.valid;
			dma_valid_q <= dma_tag.valid;
			ppu_valid_q <= ppu_tag.valid;
		end
	end

	always_ff @(posedge gbclk) begin
		adr_q      <= ext_acc.adr;
		wdata_q    <= ext_acc.wdata;
		cpu_data_q <= pick(cpu_tag.src);
		dma_data_q <= pick(dma_tag.src);
		ppu_data_q <= pick(ppu_tag.src);
	end

	assign ext = '{adr: adr_q, rd: rd_q, wr: wr_q, wdata: wdata_q, oe: oe_q,
		cs_rom: cs_rom_q, cs_xram: cs_xram_q, cs_wram: cs_wram_q};

	assign cpu_rsp = '{valid: cpu_valid_q, data: cpu_data_q};
	assign dma_rsp = '{valid: dma_valid_q, data: dma_data_q};
	assign ppu_rsp = '{valid: ppu_valid_q, data: ppu_data_q};

endmodule

`default_nettype wire

// ==== gb_bus_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_bus_fabric
	import gb_map_pkg::*, gb_bus_pkg::*;
(
	input  logic     gbclk,
	input  logic     arst_n,
	input  cpu_req_t cpu_req,
	input  dma_req_t dma_req,
	input  ppu_req_t ppu_req,
	input  gb_data_t ext_rdata,
	output rsp_t     cpu_rsp,
	output rsp_t     dma_rsp,
	output rsp_t     ppu_rsp,
	output ext_bus_t ext
);

	gb_region_e cpu_region, dma_region;
	mem_port_t  vram_port, oam_port, hram_port;
	ext_bus_t   ext_acc;
	rsp_tag_t   cpu_tag, dma_tag, ppu_tag;
	gb_data_t   vram_rdata, oam_rdata, hram_rdata;

	gb_region_decode #(.req_t(cpu_req_t)) cpu_decode_i (
		.req    (cpu_req),
		.enable (1'b1),
		.region (cpu_region)
	);

	// DMA source decodes only during a transfer.
	gb_region_decode #(.req_t(dma_req_t)) dma_decode_i (
		.req    (dma_req),
		.enable (dma_req.active),
		.region (dma_region)
	);

	gb_bus_arbiter arbiter_i (
		.gbclk      (gbclk),
		.arst_n     (arst_n),
		.cpu_req    (cpu_req),
		.dma_req    (dma_req),
		.ppu_req    (ppu_req),
		.cpu_region (cpu_region),
		.dma_region (dma_region),
		.vram_port  (vram_port),
		.oam_port   (oam_port),
		.hram_port  (hram_port),
		.ext_acc    (ext_acc),
		.cpu_tag    (cpu_tag),
		.dma_tag    (dma_tag),
		.ppu_tag    (ppu_tag)
	);

	gb_local_mem local_mem_i (
		.gbclk      (gbclk),
		.vram_port  (vram_port),
		.oam_port   (oam_port),
		.hram_port  (hram_port),
		.vram_rdata (vram_rdata),
		.oam_rdata  (oam_rdata),
		.hram_rdata (hram_rdata)
	);

	gb_read_return read_return_i (
		.gbclk      (gbclk),
		.arst_n     (arst_n),
		.ext_acc    (ext_acc),
		.ext_rdata  (ext_rdata),
		.cpu_tag    (cpu_tag),
		.dma_tag    (dma_tag),
		.ppu_tag    (ppu_tag),
		.vram_rdata (vram_rdata),
		.oam_rdata  (oam_rdata),
		.hram_rdata (hram_rdata),
		.ext        (ext),
		.cpu_rsp    (cpu_rsp),
		.dma_rsp    (dma_rsp),
		.ppu_rsp    (ppu_rsp)
	);

endmodule

`default_nettype wire

// ==== gb_bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_bus_checker
	import gb_map_pkg::*, gb_bus_pkg::*;
(
	input logic     gbclk,
	input logic     arst_n,
	input cpu_req_t cpu_req,
	input dma_req_t dma_req,
	input ppu_req_t ppu_req,
	input rsp_t     cpu_rsp,
	input rsp_t     dma_rsp,
	input rsp_t     ppu_rsp,
	input ext_bus_t ext
);

	int failures = 0;

	// One external device at a time.
	cs_onehot: assert property (@(posedge gbclk) disable iff (!arst_n)
		$onehot0({ext.cs_rom, ext.cs_xram, ext.cs_wram}))
		else begin
			$error("more than one external chip select is high");
			failures++;
		end

	wr_needs_oe: assert property (@(posedge gbclk) disable iff (!arst_n) ext.wr |-> ext.oe)
		else begin
			$error("ext.wr is high while ext.oe is low");
			failures++;
		end

	// Fixed read latency of two cycles for each master.
	cpu_latency: assert property (@(posedge gbclk) disable iff (!arst_n)
		$past(cpu_req.rd, 2) |-> cpu_rsp.valid)
		else begin
			$error("cpu read strobe without valid two cycles later");
			failures++;
		end

	dma_latency: assert property (@(posedge gbclk) disable iff (!arst_n)
		$past(dma_req.rd, 2) |-> dma_rsp.valid)
		else begin
			$error("dma read strobe without valid two cycles later");
			failures++;
		end

	ppu_latency: assert property (@(posedge gbclk) disable iff (!arst_n)
		$past(ppu_req.rd, 2) |-> ppu_rsp.valid)
		else begin
			$error("pixel unit read strobe without valid two cycles later");
			failures++;
		end

endmodule

bind gb_bus_fabric gb_bus_checker checker_i (
	.gbclk   (gbclk),
	.arst_n  (arst_n),
	.cpu_req (cpu_req),
	.dma_req (dma_req),
	.ppu_req (ppu_req),
	.cpu_rsp (cpu_rsp),
	.dma_rsp (dma_rsp),
	.ppu_rsp (ppu_rsp),
	.ext     (ext)
);

`default_nettype wire

// ==== tb_gb_bus_fabric.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_gb_bus_fabric
	import gb_map_pkg::*, gb_bus_pkg::*;
();

	localparam int MAX_WORDS = 320;
	localparam int TIMEOUT   = 8;

	logic     gbclk;
	logic     arst_n;
	cpu_req_t cpu_req;
	dma_req_t dma_req;
	ppu_req_t ppu_req;
	gb_data_t ext_rdata;
	rsp_t     cpu_rsp, dma_rsp, ppu_rsp;
	ext_bus_t ext;

	logic [15:0] case_words [MAX_WORDS];
	gb_data_t    ext_mem [65536];
	int unsigned rand_state;
	int          errors;
	int          checks;
	int          timeouts;
	logic        abort;
	logic        pend [3];
	gb_data_t    expect_byte [3];
	string       rsp_name [3] = '{"cpu_rsp", "dma_rsp", "ppu_rsp"};

	// Expected external activity of the current group.
	logic [2:0]  exp_cs;
	logic        ext_check;
	logic        ext_is_wr;
	gb_adr_t     exp_adr;
	gb_data_t    exp_wdata;

	gb_bus_fabric gb_bus_fabric_i (
		.gbclk     (gbclk),
		.arst_n    (arst_n),
		.cpu_req   (cpu_req),
		.dma_req   (dma_req),
		.ppu_req   (ppu_req),
		.ext_rdata (ext_rdata),
		.cpu_rsp   (cpu_rsp),
		.dma_rsp   (dma_rsp),
		.ppu_rsp   (ppu_rsp),
		.ext       (ext)
	);

	initial begin
		gbclk = 1'b0;
		forever #5 gbclk = ~gbclk;
	end

	function automatic int unsigned xorshift32(input int unsigned x);
		int unsigned y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// External memory model answering from the bus address.
	assign ext_rdata = ext_mem[ext.adr];

	initial begin
		rand_state = 32'd27961;
		for (int a = 0; a < 65536; a++) begin
			rand_state = xorshift32(rand_state);
			ext_mem[a] = rand_state[7:0];
		end
		forever begin
			@(posedge gbclk);
			#1;
			if (ext.wr === 1'b1)
				ext_mem[ext.adr] = ext.wdata;
		end
	end

	function automatic rsp_t rsp_of(input int m);
		case (m)
			0:       return cpu_rsp;
			1:       return dma_rsp;
			default: return ppu_rsp;
		endcase
	endfunction

	task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic clear_inputs();
		cpu_req = '0;
		dma_req = '0;
		ppu_req = '0;
	endtask

	task automatic issue_line(input int base);
		int         m;
		int         op;
		gb_adr_t    adr;
		gb_data_t   data;
		logic [7:0] flags;
		m     = int'(case_words[base]);
		op    = int'(case_words[base+1]);
		adr   = case_words[base+2];
		data  = case_words[base+3][7:0];
		flags = case_words[base+4][7:0];
		if (flags[1])
			data = ext_mem[adr];
		if (flags[5:4] != 2'd0) begin
			ext_check = 1'b1;
			ext_is_wr = (op == 1);
			exp_adr   = adr;
			exp_wdata = data;
			case (flags[5:4])
				2'd1:    exp_cs = 3'b100;
				2'd2:    exp_cs = 3'b010;
				default: exp_cs = 3'b001;
			endcase
		end
		case (m)
			0: begin
				cpu_req.rd    = (op == 0);
				cpu_req.wr    = (op == 1);
				cpu_req.adr   = adr;
				cpu_req.wdata = data;
			end
			1: begin
				// The address column holds the OAM index for a DMA write.
				dma_req.active  = 1'b1;
				dma_req.rd      = (op == 0);
				dma_req.wr      = (op == 1);
				dma_req.adr     = (op == 1) ? '0 : adr;
				dma_req.oam_idx = gb_idx_t'(adr);
				dma_req.wdata   = data;
			end
			default: begin
				ppu_req.need_vram = adr < 16'hA000;
				ppu_req.need_oam  = adr >= 16'hFE00;
				ppu_req.rd        = (op == 0);
				ppu_req.adr       = adr;
			end
		endcase
		if (op == 0) begin
			pend[m]        = 1'b1;
			expect_byte[m] = data;
		end
	endtask

	task automatic await_group();
		int   cycle;
		int   m;
		logic busy;
		rsp_t rsp;
		cycle = 0;
		busy  = 1'b1;
		while (busy) begin
			@(posedge gbclk);
			#1;
			cycle++;
			if (cycle == 1) begin
				clear_inputs();
				compare("ext.cs", 16'({ext.cs_rom, ext.cs_xram, ext.cs_wram}), 16'(exp_cs));
				if (ext_check) begin
					compare("ext.adr", 16'(ext.adr), 16'(exp_adr));
					if (ext_is_wr) begin
						compare("ext.wr", 16'(ext.wr), 16'd1);
						compare("ext.wdata", 16'(ext.wdata), 16'(exp_wdata));
						compare("ext.oe", 16'(ext.oe), 16'd1);
					end else begin
						compare("ext.rd", 16'(ext.rd), 16'd1);
						compare("ext.oe", 16'(ext.oe), 16'd0);
					end
				end
			end
			if (cycle == 2 && ext_check && ext_is_wr) begin
				compare("ext.wr", 16'(ext.wr), 16'd0);
				compare("ext.oe", 16'(ext.oe), 16'd1);
			end
			for (m = 0; m < 3; m++) begin
				rsp = rsp_of(m);
				if (pend[m] && rsp.valid) begin
					compare({rsp_name[m], " latency"}, 16'(cycle), 16'd2);
					compare({rsp_name[m], ".data"}, 16'(rsp.data), 16'(expect_byte[m]));
					pend[m] = 1'b0;
				end else if (!pend[m] && rsp.valid) begin
					errors++;
					$display("Unexpected valid on %s at %0t ns", rsp_name[m], $time);
				end
			end
			busy = (cycle < 2) || pend[0] || pend[1] || pend[2];
			if (busy && cycle >= TIMEOUT) begin
				$display("Timeout: a read got no valid response within %0d cycles", TIMEOUT);
				timeouts++;
				errors++;
				abort = 1'b1;
				busy  = 1'b0;
			end
		end
	endtask

	initial begin
		int   idx;
		logic grouped;
		errors   = 0;
		checks   = 0;
		timeouts = 0;
		abort    = 1'b0;
		arst_n   = 1'b0;
		clear_inputs();
		for (int i = 0; i < 3; i++) begin
			pend[i]        = 1'b0;
			expect_byte[i] = '0;
		end
		for (int w = 0; w < MAX_WORDS; w++)
			case_words[w] = 16'h000F;
		$readmemh("gb_bus_cases.txt", case_words);

		repeat (4) @(posedge gbclk);
		#1;
		arst_n = 1'b1;

		// Lines flagged with bit 0 go out in the same cycle as the next one.
		idx = 0;
		while (!abort && idx + 5 <= MAX_WORDS && case_words[idx] != 16'h000F) begin
			exp_cs    = 3'b000;
			ext_check = 1'b0;
			ext_is_wr = 1'b0;
			do begin
				issue_line(idx);
				grouped = case_words[idx+4][0];
				idx += 5;
			end while (grouped && idx + 5 <= MAX_WORDS);
			await_group();
		end

		if (checks == 0) begin
			$display("No checks ran, the case file is empty or missing");
			errors++;
		end
		errors += gb_bus_fabric_i.checker_i.failures;
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== gb_bus_cases.txt ====
// master (0 cpu, 1 dma, 2 pixel unit), op (0 read, 1 write, 2 held), address, byte, flags
// flags: 01 same cycle as next line, 02 byte from external model, 10/20/30 rom/xram/wram select
0 1 8000 5A 00
0 0 8000 5A 00
0 1 FE10 C3 00
0 0 FE10 C3 00
0 1 FF80 77 00
0 0 FF80 77 00
0 0 0123 00 12
0 0 A456 00 22
0 0 C789 00 32
0 1 D000 3C 30
0 0 D000 3C 30
2 2 8000 00 01
0 0 8000 FF 00
1 2 0000 00 01
0 1 FE10 99 00
0 0 FE10 C3 00
1 0 C789 00 32
1 0 8000 5A 00
1 1 0020 E1 00
0 0 FE20 E1 00
0 0 FF00 FF 00
0 0 FEA0 FF 00
0 0 FFFF FF 00
2 0 8000 5A 01
0 0 8000 FF 00
2 0 FE10 C3 01
0 0 FE10 FF 00
F 0 0000 00 00

// ==== project.f ====
+incdir+.
gb_map_pkg.sv
gb_bus_pkg.sv
gb_region_decode.sv
gb_bus_arbiter.sv
gb_local_mem.sv
gb_read_return.sv
gb_bus_fabric.sv
gb_bus_checker.sv
tb_gb_bus_fabric.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	-f project.f --top-module tb_gb_bus_fabric -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx ">>> PASS" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
